//--- src/bf16_pkg.sv
package bf16_pkg;

	// bfloat16 field layout
	// sign on top, then exponent, then stored mantissa
	localparam int BF16_W = 16;
	localparam int EXP_W = 8;
	localparam int MAN_W = 7;
	localparam int SIGN_POS = BF16_W - 1;
	localparam int EXP_LSB = MAN_W;

	// significand width including the hidden one
	localparam int FRAC_W = MAN_W + 1;

	// width of the normalise shift count
	localparam int SHIFT_CNT_W = 4;

	typedef logic [BF16_W-1:0] bf16_t;
	typedef logic [EXP_W-1:0] exp_t;
	typedef logic [MAN_W-1:0] man_t;
	typedef logic [SHIFT_CNT_W-1:0] shift_cnt_t;

	// largest finite exponent, used when the sum overflows
	localparam exp_t EXP_MAX_FINITE = 8'd254;

	// controller sequence
	// align, combine and fix run once, norm loops
	typedef enum logic [2:0]
	{
		ST_IDLE = 3'd0,
		ST_ALIGN = 3'd1,
		ST_COMBINE = 3'd2,
		ST_FIX = 3'd3,
		ST_NORM = 3'd4,
		ST_DONE = 3'd5
	} add_state_t;

endpackage

//--- src/bf16_stage_if.sv
`timescale 1ns/10ps

interface bf16_stage_if #(
	parameter int GUARD_BITS = 3
);
	import bf16_pkg::*;

	// carry bit + hidden bit + mantissa + guard bits
	localparam int SIG_W = FRAC_W + GUARD_BITS + 1;

	// exponent of the larger operand, also the starting result exponent
	exp_t big_exp;
	// both significands already lined up to big_exp
	logic [SIG_W-1:0] sig_big;
	logic [SIG_W-1:0] sig_small;
	logic sign_big;
	// signs differ once op_sub has been applied to b
	logic eff_sub;
	// nothing left of the small operand
	logic zero_small;

	modport src (output big_exp, sig_big, sig_small, sign_big, eff_sub, zero_small);
	modport dst (input big_exp, sig_big, sig_small, sign_big, eff_sub, zero_small);

endinterface

//--- src/bf16_align.sv
`timescale 1ns/10ps

module bf16_align #(
	parameter int GUARD_BITS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic capture,
	input bf16_pkg::bf16_t op_a,
	input bf16_pkg::bf16_t op_b,
	input logic op_sub,
	bf16_stage_if.src stage
);
	import bf16_pkg::*;

	localparam int SIG_W = FRAC_W + GUARD_BITS + 1;

	typedef logic [SIG_W-1:0] sig_t;

	// hidden one in front, guard bits zero, carry bit clear
	// exponent 0 stands for zero, the mantissa is dropped
	function automatic sig_t unpack_sig(bf16_t w);
		man_t man;
		man = w[MAN_W-1:0];
		if (w[EXP_LSB +: EXP_W] == '0)
			return '0;
		return {1'b0, 1'b1, man, {GUARD_BITS{1'b0}}};
	endfunction

	exp_t exp_a;
	exp_t exp_b;
	exp_t exp_diff;
	exp_t exp_big_n;
	logic sign_a;
	logic sign_b;
	logic a_is_big;
	sig_t sig_a;
	sig_t sig_b;
	sig_t sig_big_n;
	sig_t sig_small_n;
	sig_t lost_mask;
	sig_t small_shifted;
	logic sticky;

	always_comb
	begin
		exp_a = op_a[EXP_LSB +: EXP_W];
		exp_b = op_b[EXP_LSB +: EXP_W];
		sign_a = op_a[SIGN_POS];
		// a - b is a + (-b)
		sign_b = op_b[SIGN_POS] ^ op_sub;
		sig_a = unpack_sig(op_a);
		sig_b = unpack_sig(op_b);

		// ties go to a, so an equal-exponent difference can still go negative
		a_is_big = (exp_a >= exp_b);
		exp_big_n = a_is_big ? exp_a : exp_b;
		exp_diff = a_is_big ? (exp_a - exp_b) : (exp_b - exp_a);
		sig_big_n = a_is_big ? sig_a : sig_b;
		sig_small_n = a_is_big ? sig_b : sig_a;

		// everything below the shift amount is lost
		// once the distance reaches SIG_W the mask covers the whole word
		// and only the sticky bit survives
		lost_mask = ~({SIG_W{1'b1}} << exp_diff);
		sticky = |(sig_small_n & lost_mask);
		small_shifted = (sig_small_n >> exp_diff) | {{(SIG_W-1){1'b0}}, sticky};
	end

	// operand payload
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			stage.big_exp <= exp_big_n;
			stage.sig_big <= sig_big_n;
			stage.sig_small <= small_shifted;
		end
	end

	// flags steering the significand unit
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			stage.sign_big <= 1'b0;
			stage.eff_sub <= 1'b0;
			stage.zero_small <= 1'b0;
		end
		else if (capture)
		begin
			stage.sign_big <= a_is_big ? sign_a : sign_b;
			stage.eff_sub <= sign_a ^ sign_b;
			stage.zero_small <= (small_shifted == '0);
		end
	end

endmodule

//--- src/bf16_sig_unit.sv
`timescale 1ns/10ps

module bf16_sig_unit #(
	parameter int GUARD_BITS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic combine,
	input logic fix,
	input logic norm_step,
	bf16_stage_if.dst stage,
	output logic norm_msb_set,
	output logic exp_low,
	output bf16_pkg::bf16_t result
);
	import bf16_pkg::*;

	localparam int SIG_W = FRAC_W + GUARD_BITS + 1;
	// position of the hidden one inside the working word
	localparam int HID_POS = SIG_W - 2;

	typedef logic [SIG_W-1:0] sig_t;

	// working significand with the carry bit on top
	sig_t acc;
	exp_t exp_r;
	logic sign_r;

	sig_t raw_sum;
	sig_t raw_diff;
	logic diff_neg;
	logic [EXP_W:0] exp_inc;
	logic sat;
	logic flush;
	man_t res_man;

	always_comb
	begin
		raw_sum = stage.sig_big + stage.sig_small;
		raw_diff = stage.sig_big - stage.sig_small;
		// only possible with equal exponents
		diff_neg = raw_diff[SIG_W-1];

		// carry out of the add bumps the exponent by one
		exp_inc = {1'b0, exp_r} + {{EXP_W{1'b0}}, acc[SIG_W-1]};
		// 255 and above cannot be encoded as finite
		sat = (exp_inc >= {1'b0, {EXP_W{1'b1}}});
	end

	// significand path
	always_ff @(posedge clk)
	begin
		if (combine)
		begin
			if (stage.zero_small)
				acc <= stage.sig_big;
			else if (!stage.eff_sub)
				acc <= raw_sum;
			else if (diff_neg)
				// back to sign-magnitude
				acc <= -raw_diff;
			else
				acc <= raw_diff;
		end
		else if (fix)
		begin
			if (acc != '0 && sat)
				acc <= {1'b0, {(SIG_W-1){1'b1}}};
			else if (acc[SIG_W-1])
				// one bit right with the dropped bit folded into sticky
				acc <= {1'b0, acc[SIG_W-1:2], acc[1] | acc[0]};
		end
		else if (norm_step)
		begin
			acc <= acc << 1;
		end
	end

	// exponent and sign
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_r <= '0;
			sign_r <= 1'b0;
		end
		else if (combine)
		begin
			exp_r <= stage.big_exp;
			// negated difference flips the result sign
			if (stage.eff_sub && !stage.zero_small && diff_neg)
				sign_r <= ~stage.sign_big;
			else
				sign_r <= stage.sign_big;
		end
		else if (fix)
		begin
			if (acc == '0)
			begin
				// exact cancellation gives +0
				exp_r <= '0;
				sign_r <= 1'b0;
			end
			else if (sat)
				exp_r <= EXP_MAX_FINITE;
			else
				exp_r <= exp_inc[EXP_W-1:0];
		end
		else if (norm_step)
		begin
			exp_r <= exp_r - exp_t'(1);
		end
	end

	// status for the normalise loop
	assign norm_msb_set = acc[HID_POS];
	// one more shift would hit exponent 0
	assign exp_low = (exp_r <= exp_t'(1));

	// pack with the guard bits truncated
	// zero exponent or a missing hidden one flushes to +0
	always_comb
	begin
		res_man = acc[GUARD_BITS +: MAN_W];
		flush = (exp_r == '0) || !acc[HID_POS];
		if (flush)
			result = '0;
		else
			result = {sign_r, exp_r, res_man};
	end

endmodule

//--- src/bf16_shift_counter.sv
`timescale 1ns/10ps

module bf16_shift_counter #(
	parameter int GUARD_BITS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic cnt_clear,
	input logic norm_step,
	output logic cnt_done
);
	import bf16_pkg::*;

	// enough shifts to walk a sticky-only result up to the hidden bit
	localparam shift_cnt_t SHIFT_LIMIT = shift_cnt_t'(FRAC_W + GUARD_BITS);

	shift_cnt_t cnt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			cnt <= '0;
		else if (cnt_clear)
			cnt <= '0;
		else if (norm_step && !cnt_done)
			cnt <= cnt + shift_cnt_t'(1);
	end

	// hard bound on the loop
	assign cnt_done = (cnt == SHIFT_LIMIT);

endmodule

//--- src/bf16_add_ctrl.sv
`timescale 1ns/10ps

module bf16_add_ctrl (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	output logic capture,
	output logic combine,
	output logic fix,
	output logic norm_step,
	output logic cnt_clear,
	input logic norm_msb_set,
	input logic exp_low,
	input logic cnt_done
);
	import bf16_pkg::*;

	add_state_t state;
	add_state_t state_next;
	logic norm_exit;

	// normalised, out of exponent range, or out of shifts
	assign norm_exit = norm_msb_set | exp_low | cnt_done;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		in_ready = 1'b0;
		out_valid = 1'b0;
		capture = 1'b0;
		combine = 1'b0;
		fix = 1'b0;
		norm_step = 1'b0;
		cnt_clear = 1'b0;

		case (state)
		ST_IDLE:
		begin
			in_ready = 1'b1;
			if (in_valid)
			begin
				capture = 1'b1;
				state_next = ST_ALIGN;
			end
		end
		// aligned operands are on the stage bus now
		ST_ALIGN:
			state_next = ST_COMBINE;
		ST_COMBINE:
		begin
			combine = 1'b1;
			state_next = ST_FIX;
		end
		ST_FIX:
		begin
			fix = 1'b1;
			cnt_clear = 1'b1;
			state_next = ST_NORM;
		end
		// one left shift per cycle until the exit test holds
		ST_NORM:
		begin
			if (norm_exit)
				state_next = ST_DONE;
			else
				norm_step = 1'b1;
		end
		// result held until taken
		ST_DONE:
		begin
			out_valid = 1'b1;
			if (out_ready)
				state_next = ST_IDLE;
		end
		default:
			state_next = ST_IDLE;
		endcase
	end

endmodule

//--- src/bf16_addsub_top.sv
`timescale 1ns/10ps

module bf16_addsub_top #(
	parameter int GUARD_BITS = 3
) (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input bf16_pkg::bf16_t op_a,
	input bf16_pkg::bf16_t op_b,
	input logic op_sub,
	output logic out_valid,
	input logic out_ready,
	output bf16_pkg::bf16_t result
);

	// step strobes from the controller
	logic capture;
	logic combine;
	logic fix;
	logic norm_step;
	logic cnt_clear;
	// loop status back to the controller
	logic norm_msb_set;
	logic exp_low;
	logic cnt_done;

	// aligner to significand unit
	bf16_stage_if #(.GUARD_BITS(GUARD_BITS)) stage ();

	bf16_align #(.GUARD_BITS(GUARD_BITS)) u_align (
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.op_a(op_a),
		.op_b(op_b),
		.op_sub(op_sub),
		.stage(stage.src)
	);

	bf16_sig_unit #(.GUARD_BITS(GUARD_BITS)) u_sig_unit (
		.clk(clk),
		.rst_n(rst_n),
		.combine(combine),
		.fix(fix),
		.norm_step(norm_step),
		.stage(stage.dst),
		.norm_msb_set(norm_msb_set),
		.exp_low(exp_low),
		.result(result)
	);

	bf16_shift_counter #(.GUARD_BITS(GUARD_BITS)) u_shift_counter (
		.clk(clk),
		.rst_n(rst_n),
		.cnt_clear(cnt_clear),
		.norm_step(norm_step),
		.cnt_done(cnt_done)
	);

	bf16_add_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.capture(capture),
		.combine(combine),
		.fix(fix),
		.norm_step(norm_step),
		.cnt_clear(cnt_clear),
		.norm_msb_set(norm_msb_set),
		.exp_low(exp_low),
		.cnt_done(cnt_done)
	);

endmodule

//--- tests/bf16_ref_model.svh
`ifndef BF16_REF_MODEL_SVH
`define BF16_REF_MODEL_SVH

// guard bits below the stored mantissa
localparam int REF_GUARD = 3;
// carry + hidden one + 7 mantissa bits + guard bits
localparam int REF_SIG_W = 8 + REF_GUARD + 1;
localparam int REF_HID = REF_SIG_W - 2;

// hidden one in front, guard bits empty
// exponent 0 means zero
function automatic int ref_unpack(input logic [15:0] w);
	if (w[14:7] == 8'd0)
		return 0;
	return (128 + int'(w[6:0])) << REF_GUARD;
endfunction

// expected truncated bfloat16 result of a + b, or a - b when sub is set
function automatic logic [15:0] ref_addsub(input logic [15:0] a, input logic [15:0] b,
	input logic sub);
	int ea;
	int eb;
	int sa;
	int sb;
	int sig_hi;
	int sig_lo;
	int e;
	int shift_amt;
	int lost;
	int acc;
	int sign;
	int steps;
	ea = int'(a[14:7]);
	eb = int'(b[14:7]);
	sa = int'(a[15]);
	// subtraction flips the sign of b
	sb = int'(b[15] ^ sub);
	// larger exponent leads, a wins a tie
	if (ea >= eb)
	begin
		e = ea;
		shift_amt = ea - eb;
		sig_hi = ref_unpack(a);
		sig_lo = ref_unpack(b);
		sign = sa;
	end
	else
	begin
		e = eb;
		shift_amt = eb - ea;
		sig_hi = ref_unpack(b);
		sig_lo = ref_unpack(a);
		sign = sb;
	end
	// shifted out bits collapse into bit 0
	if (shift_amt >= REF_SIG_W)
		sig_lo = (sig_lo != 0) ? 1 : 0;
	else
	begin
		lost = sig_lo % (1 << shift_amt);
		sig_lo = sig_lo >> shift_amt;
		if (lost != 0)
			sig_lo = sig_lo | 1;
	end
	// sign-magnitude add or subtract
	if (sig_lo == 0)
		acc = sig_hi;
	else if (sa == sb)
		acc = sig_hi + sig_lo;
	else
	begin
		acc = sig_hi - sig_lo;
		if (acc < 0)
		begin
			acc = -acc;
			sign = 1 - sign;
		end
	end
	// exact cancellation is +0
	if (acc == 0)
		return 16'h0000;
	// carry out, keep the dropped bit as sticky
	if (acc >= (1 << (REF_SIG_W - 1)))
	begin
		acc = (acc >> 1) | (acc & 1);
		e = e + 1;
	end
	// clamp to largest finite value
	if (e >= 255)
	begin
		acc = (1 << (REF_SIG_W - 1)) - 1;
		e = 254;
	end
	steps = 0;
	while (acc < (1 << REF_HID) && e > 1 && steps < 8 + REF_GUARD)
	begin
		acc = acc << 1;
		e = e - 1;
		steps = steps + 1;
	end
	// flush to zero when normalisation ran out of exponent
	if (acc < (1 << REF_HID) || e == 0)
		return 16'h0000;
	return {1'(sign), 8'(e), 7'((acc >> REF_GUARD) & 127)};
endfunction

`endif

//--- tests/tb_bf16_addsub.sv
`timescale 1ns/10ps

module tb_bf16_addsub;

	localparam int RAND_OPS = 200;
	// directed operations ahead of the random sweep
	localparam int DIRECTED_OPS = 22;
	// operations over all tests for the watchdog
	localparam int NUM_OPS = DIRECTED_OPS + RAND_OPS;
	localparam int WAIT_LIMIT = 40;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [15:0] op_a;
	logic [15:0] op_b;
	logic op_sub;
	logic out_valid;
	logic out_ready;
	logic [15:0] result;

	int errors;
	int tests;
	int seed;

	`include "bf16_ref_model.svh"

	bf16_addsub_top #(.GUARD_BITS(3)) dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.op_a(op_a),
		.op_b(op_b),
		.op_sub(op_sub),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.result(result)
	);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// one edge and a short step past it before driving
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// wait for in_ready and present one operation for one edge
	task automatic start_op(input logic [15:0] a, input logic [15:0] b, input logic sub);
		int waited;
		waited = 0;
		while (!in_ready && waited < WAIT_LIMIT)
		begin
			next_cycle();
			waited = waited + 1;
		end
		if (!in_ready)
		begin
			$display("ERROR: in_ready never came up for operands %h %h", a, b);
			errors = errors + 1;
		end
		op_a = a;
		op_b = b;
		op_sub = sub;
		in_valid = 1'b1;
		next_cycle();
		in_valid = 1'b0;
	endtask

	// cycles counted from the accept edge
	task automatic wait_out(output int cycles);
		cycles = 0;
		while (!out_valid && cycles < WAIT_LIMIT)
		begin
			next_cycle();
			cycles = cycles + 1;
		end
		if (!out_valid)
		begin
			$display("ERROR: out_valid never came up after %0d cycles", cycles);
			errors = errors + 1;
		end
	endtask

	task automatic take_out();
		out_ready = 1'b1;
		next_cycle();
		out_ready = 1'b0;
	endtask

	task automatic check_op(input string name, input logic [15:0] a, input logic [15:0] b,
		input logic sub, input logic [15:0] expected);
		int cycles;
		start_op(a, b, sub);
		wait_out(cycles);
		if (result !== expected)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, result);
			errors = errors + 1;
		end
		take_out();
		tests = tests + 1;
	endtask

	task automatic reset_and_latency();
		int cycles;
		logic [15:0] expected;
		expected = ref_addsub(16'h3FC0, 16'h3FA0, 1'b0);
		if (in_ready !== 1'b1)
		begin
			$display("FAIL reset_in_ready expected 1 actual %b", in_ready);
			errors = errors + 1;
		end
		if (out_valid !== 1'b0)
		begin
			$display("FAIL reset_out_valid expected 0 actual %b", out_valid);
			errors = errors + 1;
		end
		// 1.5 plus 1.25 with equal exponents
		start_op(16'h3FC0, 16'h3FA0, 1'b0);
		wait_out(cycles);
		if (cycles != 4)
		begin
			$display("FAIL reset_latency expected 4 actual %0d", cycles);
			errors = errors + 1;
		end
		if (result !== expected)
		begin
			$display("FAIL reset_sum expected %h actual %h", expected, result);
			errors = errors + 1;
		end
		// carry lifts 127 to 128
		if (result[14:7] !== 8'd128)
		begin
			$display("FAIL reset_carry_exp expected 80 actual %h", result[14:7]);
			errors = errors + 1;
		end
		take_out();
		tests = tests + 1;
	endtask

	task automatic alignment_sweep();
		int shifts[4];
		int i;
		logic [15:0] a;
		logic [15:0] b;
		shifts = '{1, 3, 8, 20};
		for (i = 0; i < 4; i = i + 1)
		begin
			a = {1'b0, 8'd140, 7'h55};
			b = {1'b0, 8'(140 - shifts[i]), 7'h2B};
			// 20 leaves only the sticky bit
			check_op($sformatf("align_%0d", shifts[i]), a, b, 1'b0, ref_addsub(a, b, 1'b0));
			// small operand on the a side
			check_op($sformatf("align_swap_%0d", shifts[i]), b, a, 1'b0,
				ref_addsub(b, a, 1'b0));
		end
	endtask

	task automatic effective_subtract();
		// 1 minus 255/256 needs eight normalise steps
		check_op("sub_near_cancel", 16'h3F80, 16'h3F7F, 1'b1,
			ref_addsub(16'h3F80, 16'h3F7F, 1'b1));
		check_op("sub_near_cancel_2", 16'h4000, 16'h3FFF, 1'b1,
			ref_addsub(16'h4000, 16'h3FFF, 1'b1));
		// opposite signs through the add path
		check_op("sub_opposite", 16'h4040, 16'hC03F, 1'b0,
			ref_addsub(16'h4040, 16'hC03F, 1'b0));
		// equal exponents with b larger flip the sign
		check_op("sub_neg_diff", 16'h3F80, 16'h3FC0, 1'b1, 16'hBF00);
		check_op("sub_exact_zero", 16'h4120, 16'h4120, 1'b1, 16'h0000);
		check_op("sub_exact_mixed", 16'hC120, 16'h4120, 1'b0, 16'h0000);
	endtask

	task automatic saturation_and_zero();
		// exponent 254 twice overflows
		check_op("sat_max", 16'h7F40, 16'h7F40, 1'b0, 16'h7F7F);
		check_op("sat_model", 16'h7F7F, 16'h7F00, 1'b0, ref_addsub(16'h7F7F, 16'h7F00, 1'b0));
		// exponent 0 operands are zero whatever the mantissa
		check_op("zero_b", 16'h4049, 16'h0035, 1'b0, 16'h4049);
		check_op("zero_a", 16'h0012, 16'hC0A3, 1'b0, 16'hC0A3);
		check_op("zero_a_sub", 16'h0012, 16'h40A3, 1'b1, 16'hC0A3);
	endtask

	task automatic backpressure_hold();
		logic [15:0] held;
		logic [15:0] expected;
		int cycles;
		int i;
		expected = ref_addsub(16'h4000, 16'h3F80, 1'b1);
		start_op(16'h4000, 16'h3F80, 1'b1);
		wait_out(cycles);
		held = result;
		// consumer stalls for 6 cycles
		for (i = 0; i < 6; i = i + 1)
		begin
			next_cycle();
			if (out_valid !== 1'b1)
			begin
				$display("FAIL backpressure_valid expected 1 actual %b", out_valid);
				errors = errors + 1;
			end
			if (result !== held)
			begin
				$display("FAIL backpressure_hold expected %h actual %h", held, result);
				errors = errors + 1;
			end
			if (in_ready !== 1'b0)
			begin
				$display("FAIL backpressure_in_ready expected 0 actual %b", in_ready);
				errors = errors + 1;
			end
		end
		if (held !== expected)
		begin
			$display("FAIL backpressure_result expected %h actual %h", expected, held);
			errors = errors + 1;
		end
		take_out();
		tests = tests + 1;
		// ready again right after the output transfer
		if (in_ready !== 1'b1)
		begin
			$display("FAIL backpressure_next_ready expected 1 actual %b", in_ready);
			errors = errors + 1;
		end
		check_op("backpressure_next", 16'h3F80, 16'h3F80, 1'b0, 16'h4000);
	endtask

	// exponents 1 to 250 keep sums below saturation
	function automatic logic [15:0] rand_operand();
		int e;
		int m;
		int s;
		e = 1 + int'($unsigned($random(seed)) % 250);
		m = $random(seed) & 127;
		s = $random(seed) & 1;
		return {1'(s), 8'(e), 7'(m)};
	endfunction

	task automatic random_sweep();
		int i;
		logic [15:0] a;
		logic [15:0] b;
		logic sub;
		for (i = 0; i < RAND_OPS; i = i + 1)
		begin
			a = rand_operand();
			b = rand_operand();
			sub = 1'($random(seed));
			check_op($sformatf("random_%0d", i), a, b, sub, ref_addsub(a, b, sub));
		end
	endtask

	initial
	begin
		seed = 32'h9451_ba96;
		errors = 0;
		tests = 0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		op_a = 16'h0000;
		op_b = 16'h0000;
		op_sub = 1'b0;
		out_ready = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		next_cycle();
		reset_and_latency();
		alignment_sweep();
		effective_subtract();
		saturation_and_zero();
		backpressure_hold();
		random_sweep();
		$display("errors: %0d, operations checked: %0d", errors, tests);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// worst case well under 40 cycles per operation
	initial
	begin
		repeat (NUM_OPS * 40) @(posedge clk);
		$display("ERROR: watchdog expired before all tests finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- project.f
+incdir+tests
src/bf16_pkg.sv
src/bf16_stage_if.sv
src/bf16_align.sv
src/bf16_sig_unit.sv
src/bf16_shift_counter.sv
src/bf16_add_ctrl.sv
src/bf16_addsub_top.sv
tests/tb_bf16_addsub.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f project.f --top-module tb_bf16_addsub -o tb_bf16_addsub
out=$(./obj_dir/tb_bf16_addsub)
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
	exit 0
fi
exit 1
